// File: logic/csr_pkg.sv
package csr_pkg;

    typedef logic [13:0] csr_addr_t;
    typedef logic [31:0] csr_word_t;

    // exception and interrupt registers
    localparam csr_addr_t ADDR_CRMD   = 14'h0;
    localparam csr_addr_t ADDR_PRMD   = 14'h1;
    localparam csr_addr_t ADDR_ECFG   = 14'h4;
    localparam csr_addr_t ADDR_ESTAT  = 14'h5;
    localparam csr_addr_t ADDR_ERA    = 14'h6;
    localparam csr_addr_t ADDR_BADV   = 14'h7;
    localparam csr_addr_t ADDR_EENTRY = 14'hc;

    // scratch words
    localparam csr_addr_t ADDR_SAVE0  = 14'h30;
    localparam csr_addr_t ADDR_SAVE1  = 14'h31;
    localparam csr_addr_t ADDR_SAVE2  = 14'h32;
    localparam csr_addr_t ADDR_SAVE3  = 14'h33;

    // stable timer
    localparam csr_addr_t ADDR_TID    = 14'h40;
    localparam csr_addr_t ADDR_TCFG   = 14'h41;
    localparam csr_addr_t ADDR_TVAL   = 14'h42;
    localparam csr_addr_t ADDR_TICLR  = 14'h44;

    // crmd fields, prmd keeps pplv/pie at the same positions
    localparam int PLV_W       = 2;
    localparam int CRMD_IE_BIT = 2;
    localparam int CRMD_DA_BIT = 3;

    // estat fields
    localparam int ECODE_LSB     = 16;
    localparam int ECODE_W       = 6;
    localparam int ESUBCODE_LSB  = 22;
    localparam int ESUBCODE_W    = 9;
    localparam int HW_INT_LSB    = 2;
    localparam int HW_INT_W      = 8;
    localparam int TIMER_INT_BIT = 11;

    // width of the status and enable vectors for has_int
    localparam int INT_W = 13;

    // timer fields
    localparam int TCFG_EN_BIT       = 0;
    localparam int TCFG_PERIODIC_BIT = 1;
    localparam int TIMER_SHIFT       = 2;
    localparam int TICLR_CLR_BIT     = 0;

    // software writable bits per register
    localparam csr_word_t CRMD_WMASK   = 32'h0000_01ff;
    localparam csr_word_t PRMD_WMASK   = 32'h0000_0007;
    localparam csr_word_t ECFG_WMASK   = 32'h0000_1bff;
    localparam csr_word_t ESTAT_WMASK  = 32'h0000_0003;
    localparam csr_word_t EENTRY_WMASK = 32'hffff_ffc0;
    localparam csr_word_t TCFG_WMASK   = 32'hffff_ffff;

    // direct address mode out of reset
    localparam csr_word_t CRMD_RESET = csr_word_t'(1) << CRMD_DA_BIT;

endpackage

// File: logic/exception_csrs.sv
`timescale 1ns/10ps

module exception_csrs import csr_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  csr_word_t             wdata,
    input  logic                  crmd_we,
    input  logic                  prmd_we,
    input  logic                  ecfg_we,
    input  logic                  estat_we,
    input  logic                  era_we,
    input  logic                  badv_we,
    input  logic                  eentry_we,
    input  logic                  excp_flush,
    input  csr_word_t             era_in,
    input  logic [ECODE_W-1:0]    ecode_in,
    input  logic [ESUBCODE_W-1:0] esubcode_in,
    input  logic                  ertn_flush,
    input  csr_word_t             error_vaddr,
    input  logic                  error_va_en,
    input  logic [HW_INT_W-1:0]   hw_int,
    input  logic                  timer_int,
    output csr_word_t             crmd,
    output csr_word_t             prmd,
    output csr_word_t             ecfg,
    output csr_word_t             estat,
    output csr_word_t             era,
    output csr_word_t             badv,
    output csr_word_t             eentry,
    output logic [PLV_W-1:0]      plv,
    output logic                  has_int,
    output csr_word_t             eentry_out,
    output csr_word_t             era_out
);

    csr_word_t             estat_sw;
    logic [HW_INT_W-1:0]   hw_int_q;
    logic [ECODE_W-1:0]    ecode;
    logic [ESUBCODE_W-1:0] esubcode;

    always_ff @(posedge clk) begin
        if (reset) begin
            crmd <= CRMD_RESET;
        end else if (excp_flush) begin
            crmd[PLV_W-1:0]   <= '0;
            crmd[CRMD_IE_BIT] <= 1'b0;
        end else if (ertn_flush) begin
            crmd[PLV_W-1:0]   <= prmd[PLV_W-1:0];
            crmd[CRMD_IE_BIT] <= prmd[CRMD_IE_BIT];
        end else if (crmd_we) begin
            crmd <= wdata & CRMD_WMASK;
        end
    end

    // old plv and ie saved on entry
    always_ff @(posedge clk) begin
        if (reset) begin
            prmd <= '0;
        end else if (excp_flush) begin
            prmd[PLV_W-1:0]   <= crmd[PLV_W-1:0];
            prmd[CRMD_IE_BIT] <= crmd[CRMD_IE_BIT];
        end else if (prmd_we) begin
            prmd <= wdata & PRMD_WMASK;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ecfg <= '0;
        end else if (ecfg_we) begin
            ecfg <= wdata & ECFG_WMASK;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            estat_sw <= '0;
            hw_int_q <= '0;
            ecode    <= '0;
            esubcode <= '0;
        end else begin
            hw_int_q <= hw_int;
            if (excp_flush) begin
                ecode    <= ecode_in;
                esubcode <= esubcode_in;
            end else if (estat_we) begin
                estat_sw <= wdata & ESTAT_WMASK;
            end
        end
    end

    always_comb begin
        estat = estat_sw;
        estat[HW_INT_LSB +: HW_INT_W]     = hw_int_q;
        estat[TIMER_INT_BIT]              = timer_int;
        estat[ECODE_LSB +: ECODE_W]       = ecode;
        estat[ESUBCODE_LSB +: ESUBCODE_W] = esubcode;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            era <= '0;
        end else if (excp_flush) begin
            era <= era_in;
        end else if (era_we) begin
            era <= wdata;
        end
    end

    // software write wins over the faulting address
    always_ff @(posedge clk) begin
        if (reset) begin
            badv <= '0;
        end else if (badv_we) begin
            badv <= wdata;
        end else if (error_va_en) begin
            badv <= error_vaddr;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            eentry <= '0;
        end else if (eentry_we) begin
            eentry <= wdata & EENTRY_WMASK;
        end
    end

    // privilege level of the next cycle
    always_comb begin
        if (excp_flush) begin
            plv = '0;
        end else if (ertn_flush) begin
            plv = prmd[PLV_W-1:0];
        end else if (crmd_we) begin
            plv = wdata[PLV_W-1:0];
        end else begin
            plv = crmd[PLV_W-1:0];
        end
    end

    assign has_int    = (|(ecfg[INT_W-1:0] & estat[INT_W-1:0])) && crmd[CRMD_IE_BIT];
    assign eentry_out = eentry;
    assign era_out    = era;

    // pipeline never enters and leaves an exception in one cycle
    flush_exclusive: assert property (
        @(posedge clk) disable iff (reset) !(excp_flush && ertn_flush)
    );

endmodule

// File: logic/stable_timer.sv
`timescale 1ns/10ps

module stable_timer import csr_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  csr_word_t wdata,
    input  logic      tid_we,
    input  logic      tcfg_we,
    input  logic      ticlr_we,
    output csr_word_t tid,
    output csr_word_t tcfg,
    output csr_word_t tval,
    output logic      timer_int
);

    logic      timer_en;
    logic      expire;
    csr_word_t reload;

    assign expire = timer_en && (tval == '0);
    assign reload = {tcfg[31:TIMER_SHIFT], {TIMER_SHIFT{1'b0}}};

    always_ff @(posedge clk) begin
        if (reset) begin
            tid <= '0;
        end else if (tid_we) begin
            tid <= wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            tcfg <= '0;
        end else if (tcfg_we) begin
            tcfg <= wdata & TCFG_WMASK;
        end
    end

    // clear beats config write beats expiry
    always_ff @(posedge clk) begin
        if (reset) begin
            timer_en  <= 1'b0;
            timer_int <= 1'b0;
        end else begin
            if (tcfg_we) begin
                timer_en <= wdata[TCFG_EN_BIT];
            end else if (expire) begin
                timer_en <= tcfg[TCFG_PERIODIC_BIT];
            end
            if (ticlr_we && wdata[TICLR_CLR_BIT]) begin
                timer_int <= 1'b0;
            end else if (expire && !tcfg_we) begin
                timer_int <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            tval <= '0;
        end else if (tcfg_we) begin
            tval <= {wdata[31:TIMER_SHIFT], {TIMER_SHIFT{1'b0}}};
        end else if (timer_en) begin
            if (tval != '0) begin
                tval <= tval - 1'b1;
            end else if (tcfg[TCFG_PERIODIC_BIT]) begin
                tval <= reload;
            end else begin
                // one-shot parks at all ones
                tval <= '1;
            end
        end
    end

    pending_after_zero: assert property (
        @(posedge clk) disable iff (reset)
        $rose(timer_int) |-> $past(timer_en && (tval == '0))
    );

    tval_holds_when_idle: assert property (
        @(posedge clk) disable iff (reset)
        (!timer_en && !tcfg_we) |=> (tval == $past(tval))
    );

endmodule

// File: logic/scratch_csrs.sv
`timescale 1ns/10ps

module scratch_csrs import csr_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  csr_word_t  wdata,
    input  logic [3:0] save_we,
    output csr_word_t  save0,
    output csr_word_t  save1,
    output csr_word_t  save2,
    output csr_word_t  save3
);

    csr_word_t save_q [4];

    always_ff @(posedge clk) begin
        for (int i = 0; i < 4; i++) begin
            if (reset) begin
                save_q[i] <= '0;
            end else if (save_we[i]) begin
                save_q[i] <= wdata;
            end
        end
    end

    assign save0 = save_q[0];
    assign save1 = save_q[1];
    assign save2 = save_q[2];
    assign save3 = save_q[3];

    // strobes come from one address decode
    one_save_strobe: assert property (
        @(posedge clk) disable iff (reset) $onehot0(save_we)
    );

endmodule

// File: logic/csr_read_port.sv
`timescale 1ns/10ps

module csr_read_port import csr_pkg::*; (
    input  csr_addr_t raddr,
    input  csr_addr_t waddr,
    input  logic      wr_en,
    input  csr_word_t wdata,
    input  csr_word_t crmd,
    input  csr_word_t prmd,
    input  csr_word_t ecfg,
    input  csr_word_t estat,
    input  csr_word_t era,
    input  csr_word_t badv,
    input  csr_word_t eentry,
    input  csr_word_t save0,
    input  csr_word_t save1,
    input  csr_word_t save2,
    input  csr_word_t save3,
    input  csr_word_t tid,
    input  csr_word_t tcfg,
    input  csr_word_t tval,
    output csr_word_t rdata
);

    csr_word_t reg_data;

    // ticlr and unmapped addresses fall to zero
    always_comb begin
        case (raddr)
            ADDR_CRMD:   reg_data = crmd;
            ADDR_PRMD:   reg_data = prmd;
            ADDR_ECFG:   reg_data = ecfg;
            ADDR_ESTAT:  reg_data = estat;
            ADDR_ERA:    reg_data = era;
            ADDR_BADV:   reg_data = badv;
            ADDR_EENTRY: reg_data = eentry;
            ADDR_SAVE0:  reg_data = save0;
            ADDR_SAVE1:  reg_data = save1;
            ADDR_SAVE2:  reg_data = save2;
            ADDR_SAVE3:  reg_data = save3;
            ADDR_TID:    reg_data = tid;
            ADDR_TCFG:   reg_data = tcfg;
            ADDR_TVAL:   reg_data = tval;
            default:     reg_data = '0;
        endcase
    end

    // same-cycle write to the read address
    assign rdata = (wr_en && (waddr == raddr)) ? wdata : reg_data;

endmodule

// File: logic/csr_file.sv
`timescale 1ns/10ps

module csr_file import csr_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  csr_addr_t             raddr,
    input  csr_addr_t             waddr,
    input  logic                  wr_en,
    input  csr_word_t             wdata,
    input  logic                  excp_flush,
    input  csr_word_t             era_in,
    input  logic [ECODE_W-1:0]    ecode_in,
    input  logic [ESUBCODE_W-1:0] esubcode_in,
    input  logic                  ertn_flush,
    input  csr_word_t             error_vaddr,
    input  logic                  error_va_en,
    input  logic [HW_INT_W-1:0]   hw_int,
    output csr_word_t             rdata,
    output logic [PLV_W-1:0]      plv,
    output csr_word_t             eentry_out,
    output csr_word_t             era_out,
    output logic                  has_int
);

    logic       crmd_we;
    logic       prmd_we;
    logic       ecfg_we;
    logic       estat_we;
    logic       era_we;
    logic       badv_we;
    logic       eentry_we;
    logic       tid_we;
    logic       tcfg_we;
    logic       ticlr_we;
    logic [3:0] save_we;
    logic       timer_int;

    csr_word_t crmd, prmd, ecfg, estat, era, badv, eentry;
    csr_word_t save0, save1, save2, save3;
    csr_word_t tid, tcfg, tval;

    // write address decode
    assign crmd_we    = wr_en && (waddr == ADDR_CRMD);
    assign prmd_we    = wr_en && (waddr == ADDR_PRMD);
    assign ecfg_we    = wr_en && (waddr == ADDR_ECFG);
    assign estat_we   = wr_en && (waddr == ADDR_ESTAT);
    assign era_we     = wr_en && (waddr == ADDR_ERA);
    assign badv_we    = wr_en && (waddr == ADDR_BADV);
    assign eentry_we  = wr_en && (waddr == ADDR_EENTRY);
    assign tid_we     = wr_en && (waddr == ADDR_TID);
    assign tcfg_we    = wr_en && (waddr == ADDR_TCFG);
    assign ticlr_we   = wr_en && (waddr == ADDR_TICLR);
    assign save_we[0] = wr_en && (waddr == ADDR_SAVE0);
    assign save_we[1] = wr_en && (waddr == ADDR_SAVE1);
    assign save_we[2] = wr_en && (waddr == ADDR_SAVE2);
    assign save_we[3] = wr_en && (waddr == ADDR_SAVE3);

    exception_csrs u_exception_csrs (
        .clk(clk), .reset(reset), .wdata(wdata),
        .crmd_we(crmd_we), .prmd_we(prmd_we), .ecfg_we(ecfg_we),
        .estat_we(estat_we), .era_we(era_we), .badv_we(badv_we),
        .eentry_we(eentry_we),
        .excp_flush(excp_flush), .era_in(era_in), .ecode_in(ecode_in),
        .esubcode_in(esubcode_in), .ertn_flush(ertn_flush),
        .error_vaddr(error_vaddr), .error_va_en(error_va_en),
        .hw_int(hw_int), .timer_int(timer_int),
        .crmd(crmd), .prmd(prmd), .ecfg(ecfg), .estat(estat),
        .era(era), .badv(badv), .eentry(eentry),
        .plv(plv), .has_int(has_int),
        .eentry_out(eentry_out), .era_out(era_out)
    );

    stable_timer u_stable_timer (
        .clk(clk), .reset(reset), .wdata(wdata),
        .tid_we(tid_we), .tcfg_we(tcfg_we), .ticlr_we(ticlr_we),
        .tid(tid), .tcfg(tcfg), .tval(tval), .timer_int(timer_int)
    );

    scratch_csrs u_scratch_csrs (
        .clk(clk), .reset(reset), .wdata(wdata), .save_we(save_we),
        .save0(save0), .save1(save1), .save2(save2), .save3(save3)
    );

    csr_read_port u_csr_read_port (
        .raddr(raddr), .waddr(waddr), .wr_en(wr_en), .wdata(wdata),
        .crmd(crmd), .prmd(prmd), .ecfg(ecfg), .estat(estat),
        .era(era), .badv(badv), .eentry(eentry),
        .save0(save0), .save1(save1), .save2(save2), .save3(save3),
        .tid(tid), .tcfg(tcfg), .tval(tval),
        .rdata(rdata)
    );

endmodule

// File: dv/csr_file_tb.sv
`timescale 1ns/10ps

module csr_file_tb import csr_pkg::*; ();

    // all tests together take a few hundred cycles
    localparam int MAX_CYCLES = 3000;

    localparam csr_addr_t ZERO_ADDRS [15] = '{
        ADDR_PRMD, ADDR_ECFG, ADDR_ESTAT, ADDR_ERA, ADDR_BADV, ADDR_EENTRY,
        ADDR_SAVE0, ADDR_SAVE1, ADDR_SAVE2, ADDR_SAVE3,
        ADDR_TID, ADDR_TCFG, ADDR_TVAL, ADDR_TICLR, 14'h3ff
    };
    localparam csr_addr_t MASKED_ADDRS [9] = '{
        ADDR_SAVE0, ADDR_SAVE1, ADDR_SAVE2, ADDR_SAVE3,
        ADDR_TID, ADDR_ECFG, ADDR_EENTRY, ADDR_PRMD, ADDR_ESTAT
    };

    logic                  clk;
    logic                  reset;
    csr_addr_t             raddr;
    csr_addr_t             waddr;
    logic                  wr_en;
    csr_word_t             wdata;
    logic                  excp_flush;
    csr_word_t             era_in;
    logic [ECODE_W-1:0]    ecode_in;
    logic [ESUBCODE_W-1:0] esubcode_in;
    logic                  ertn_flush;
    csr_word_t             error_vaddr;
    logic                  error_va_en;
    logic [HW_INT_W-1:0]   hw_int;
    csr_word_t             rdata;
    logic [PLV_W-1:0]      plv;
    csr_word_t             eentry_out;
    csr_word_t             era_out;
    logic                  has_int;

    int               errors;
    int               assert_errors;
    int               tests;
    int               cycles;
    logic [PLV_W-1:0] saved_plv;

    csr_file UUT (
        .clk(clk), .reset(reset), .raddr(raddr), .waddr(waddr), .wr_en(wr_en),
        .wdata(wdata), .excp_flush(excp_flush), .era_in(era_in), .ecode_in(ecode_in),
        .esubcode_in(esubcode_in), .ertn_flush(ertn_flush), .error_vaddr(error_vaddr),
        .error_va_en(error_va_en), .hw_int(hw_int), .rdata(rdata), .plv(plv),
        .eentry_out(eentry_out), .era_out(era_out), .has_int(has_int)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("Errors found");
            $finish;
        end
    end

    // plv drops to 0 during the entry pulse
    entry_plv: assert property (@(posedge clk) disable iff (reset) excp_flush |-> plv == '0)
        else begin
            $display("Mismatch at %0t: plv expected 0, got %0d", $time, $sampled(plv));
            assert_errors++;
        end

    // and shows PRMD.PPLV during the return pulse
    return_plv: assert property (@(posedge clk) disable iff (reset)
        ertn_flush |-> plv == saved_plv)
        else begin
            $display("Mismatch at %0t: plv expected %0d, got %0d", $time, saved_plv,
                     $sampled(plv));
            assert_errors++;
        end

    function automatic csr_word_t write_mask(input csr_addr_t addr);
        case (addr)
            ADDR_PRMD:   return 32'h0000_0007;
            ADDR_ECFG:   return 32'h0000_1bff;
            ADDR_ESTAT:  return 32'h0000_0003;
            ADDR_EENTRY: return 32'hffff_ffc0;
            default:     return 32'hffff_ffff;
        endcase
    endfunction

    task automatic check_value(input string name, input csr_word_t expected,
                               input csr_word_t actual);
        assert (actual === expected)
        else begin
            $display("Mismatch at %0t: %s expected %h, got %h", $time, name, expected, actual);
            errors++;
        end
    endtask

    task automatic read_csr(input csr_addr_t addr, output csr_word_t data);
        @(negedge clk);
        wr_en = 1'b0;
        raddr = addr;
        #1;
        data = rdata;
    endtask

    task automatic check_read(input csr_addr_t addr, input csr_word_t expected);
        csr_word_t data;
        read_csr(addr, data);
        check_value($sformatf("rdata[%h]", addr), expected, data);
    endtask

    task automatic write_csr(input csr_addr_t addr, input csr_word_t data);
        @(negedge clk);
        wr_en = 1'b1;
        waddr = addr;
        wdata = data;
        @(negedge clk);
        wr_en = 1'b0;
    endtask

    task automatic finish_test(input string name);
        tests++;
        $display("test %0d (%s) finished, %0d errors so far", tests, name,
                 errors + assert_errors);
    endtask

    // k counts edges after the TCFG write edge
    task automatic run_timer(input int n, input logic periodic);
        logic pend;
        @(negedge clk);
        wr_en = 1'b1;
        waddr = ADDR_TCFG;
        wdata = (32'(n) << 2) | {30'h0, periodic, 1'b1};
        raddr = ADDR_ESTAT;
        @(negedge clk);
        wr_en = 1'b0;
        for (int k = 0; k <= 4 * n + 1; k++) begin
            if (k > 0) begin
                @(negedge clk);
            end
            #1;
            pend = (k == 4 * n + 1);
            check_value("estat[11]", 32'(pend), 32'(rdata[TIMER_INT_BIT]));
            check_value("has_int", 32'(pend), 32'(has_int));
        end
    endtask

    task automatic wait_pending(input int max_edges);
        int edges;
        edges = 0;
        @(negedge clk);
        raddr = ADDR_ESTAT;
        #1;
        while (!rdata[TIMER_INT_BIT] && edges < max_edges) begin
            @(negedge clk);
            #1;
            edges++;
        end
        if (!rdata[TIMER_INT_BIT]) begin
            $display("Timer pending bit did not set again within %0d cycles", max_edges);
            errors++;
        end
    endtask

    initial begin
        csr_word_t            rnd;
        csr_word_t            wr_vals [9];
        csr_word_t            ecfg_en;
        logic [HW_INT_W-1:0]  prev_hw;
        logic [HW_INT_W-1:0]  next_hw;
        logic                 exp_int;
        rnd = $urandom(15);
        errors = 0;
        assert_errors = 0;
        tests = 0;
        cycles = 0;
        saved_plv = '0;
        reset = 1'b1;
        raddr = '0;
        waddr = '0;
        wr_en = 1'b0;
        wdata = '0;
        excp_flush = 1'b0;
        era_in = '0;
        ecode_in = '0;
        esubcode_in = '0;
        ertn_flush = 1'b0;
        error_vaddr = '0;
        error_va_en = 1'b0;
        hw_int = '0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        check_read(ADDR_CRMD, 32'h8);
        for (int i = 0; i < 15; i++) begin
            check_read(ZERO_ADDRS[i], 32'h0);
        end
        check_value("plv", 32'h0, 32'(plv));
        check_value("has_int", 32'h0, 32'(has_int));
        finish_test("reset state");

        for (int i = 0; i < 9; i++) begin
            wr_vals[i] = $urandom;
            write_csr(MASKED_ADDRS[i], wr_vals[i]);
        end
        for (int i = 0; i < 9; i++) begin
            check_read(MASKED_ADDRS[i], wr_vals[i] & write_mask(MASKED_ADDRS[i]));
        end
        check_value("eentry_out", wr_vals[6] & 32'hffff_ffc0, eentry_out);
        @(negedge clk);
        rnd = $urandom;
        wr_en = 1'b1;
        waddr = ADDR_SAVE2;
        raddr = ADDR_SAVE2;
        wdata = rnd;
        #1;
        check_value("rdata forwarded", rnd, rdata);
        @(negedge clk);
        wr_en = 1'b0;
        check_read(ADDR_SAVE2, rnd);
        finish_test("masked writes and forwarding");

        write_csr(ADDR_ECFG, 32'h0);
        write_csr(ADDR_ESTAT, 32'h0);
        // plv follows wdata during the CRMD write
        @(negedge clk);
        wr_en = 1'b1;
        waddr = ADDR_CRMD;
        wdata = 32'h7;
        #1;
        check_value("plv", 32'h3, 32'(plv));
        @(negedge clk);
        wr_en = 1'b0;
        check_read(ADDR_CRMD, 32'h7);
        check_value("plv", 32'h3, 32'(plv));
        @(negedge clk);
        rnd = $urandom;
        era_in = $urandom;
        ecode_in = rnd[5:0];
        esubcode_in = rnd[14:6];
        excp_flush = 1'b1;
        #1;
        check_value("plv", 32'h0, 32'(plv));
        @(negedge clk);
        excp_flush = 1'b0;
        // plv and ie cleared while da stays 0
        check_read(ADDR_CRMD, 32'h0);
        check_read(ADDR_PRMD, 32'h7);
        check_read(ADDR_ESTAT, {1'b0, esubcode_in, ecode_in, 16'h0});
        check_read(ADDR_ERA, era_in);
        check_value("era_out", era_in, era_out);
        saved_plv = 2'd3;
        @(negedge clk);
        ertn_flush = 1'b1;
        #1;
        check_value("plv", 32'h3, 32'(plv));
        @(negedge clk);
        ertn_flush = 1'b0;
        check_read(ADDR_CRMD, 32'h7);
        finish_test("exception entry and return");

        @(negedge clk);
        error_vaddr = $urandom;
        error_va_en = 1'b1;
        @(negedge clk);
        error_va_en = 1'b0;
        check_read(ADDR_BADV, error_vaddr);
        @(negedge clk);
        rnd = $urandom;
        error_vaddr = $urandom;
        error_va_en = 1'b1;
        wr_en = 1'b1;
        waddr = ADDR_BADV;
        wdata = rnd;
        @(negedge clk);
        error_va_en = 1'b0;
        wr_en = 1'b0;
        check_read(ADDR_BADV, rnd);
        finish_test("faulting address");

        write_csr(ADDR_ECFG, 32'h800);
        write_csr(ADDR_CRMD, 32'h4);
        run_timer(3, 1'b0);
        check_read(ADDR_TVAL, 32'hffff_ffff);
        write_csr(ADDR_TICLR, 32'h1);
        read_csr(ADDR_ESTAT, rnd);
        check_value("estat[11]", 32'h0, 32'(rnd[TIMER_INT_BIT]));
        check_value("has_int", 32'h0, 32'(has_int));
        run_timer(2, 1'b1);
        write_csr(ADDR_TICLR, 32'h1);
        read_csr(ADDR_ESTAT, rnd);
        check_value("estat[11]", 32'h0, 32'(rnd[TIMER_INT_BIT]));
        wait_pending(9);
        write_csr(ADDR_TCFG, 32'h0);
        write_csr(ADDR_TICLR, 32'h1);
        read_csr(ADDR_ESTAT, rnd);
        check_value("estat[11]", 32'h0, 32'(rnd[TIMER_INT_BIT]));
        finish_test("timer");

        rnd = $urandom;
        ecfg_en = (rnd & 32'h0000_03fc) | 32'h0000_0004;
        write_csr(ADDR_ECFG, ecfg_en);
        for (int ie = 1; ie >= 0; ie--) begin
            write_csr(ADDR_CRMD, (ie == 1) ? 32'h4 : 32'h0);
            prev_hw = hw_int;
            repeat (12) begin
                @(negedge clk);
                raddr = ADDR_ESTAT;
                rnd = $urandom;
                next_hw = rnd[7:0];
                hw_int = next_hw;
                #1;
                // ESTAT still shows the line values from the previous cycle
                exp_int = (ie == 1) && ((prev_hw & ecfg_en[9:2]) != '0);
                check_value("estat[9:2]", 32'(prev_hw), 32'(rdata[9:2]));
                check_value("has_int", 32'(exp_int), 32'(has_int));
                prev_hw = next_hw;
            end
        end
        hw_int = '0;
        finish_test("hardware interrupts");

        errors = errors + assert_errors;
        $display("%0d tests run, %0d errors", tests, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// File: src.f
logic/csr_pkg.sv
logic/exception_csrs.sv
logic/stable_timer.sv
logic/scratch_csrs.sv
logic/csr_read_port.sv
logic/csr_file.sv
dv/csr_file_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the csr file testbench, then scan the log for the fail message
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log
verilator --binary --timing --assert -Wno-fatal -f src.f --top-module csr_file_tb \
    -o csr_file_sim > build.log 2>&1 \
    && ./obj_dir/csr_file_sim > sim.log 2>&1 \
    || { cat build.log sim.log 2>/dev/null; echo "build or simulation failed"; exit 1; }
cat sim.log
grep -q "Errors found" sim.log && { echo "simulation reported failure"; exit 1; }
grep -q "No errors" sim.log || { echo "simulation ended without a result"; exit 1; }
exit 0
